//--- tests/refill_cases.txt
// inst_req _ inst_type _ inst_addr _ data_req _ data_type _ data_addr (hex)
// type 2 is a single word and type 4 a four-beat line
1_2_00001000_0_2_00000000
0_2_00000000_1_2_00002004
1_4_00001010_0_2_00000000
0_2_00000000_1_4_00002020
1_2_00001100_1_2_00002200
1_4_00001140_1_4_00002240
1_2_00003000_0_2_00000000
1_4_00003040_1_2_00004008
1_2_00003100_1_4_00004100
0_2_00000000_1_2_00006010
1_4_00007000_1_4_00008000

//--- tb.f
+incdir+design
design/bridge_pkg.sv
design/refill_if.sv
design/refill_arbiter.sv
design/axi_read_master.sv
design/refill_counter.sv
design/core_read_bridge.sv
tests/clock_gen.sv
tests/axi_mem_model.sv
tests/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the refill bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

//--- tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

module tb_top;

    localparam int NUM_CASES     = 11;
    localparam int CASE_W        = 80;
    localparam int STALL_ALLOW   = 8;
    localparam int TIMEOUT_LIMIT = NUM_CASES * `BRIDGE_LINE_BEATS * STALL_ALLOW;

    logic                       aclk;
    logic                       rst_n;
    logic                       inst_rd_req;
    bridge_pkg::rd_type_t       inst_rd_type;
    logic [`BRIDGE_ADDR_W-1:0]  inst_rd_addr;
    logic                       inst_rd_rdy;
    logic                       inst_ret_valid;
    logic                       inst_ret_last;
    logic [`BRIDGE_DATA_W-1:0]  inst_ret_data;
    logic                       data_rd_req;
    bridge_pkg::rd_type_t       data_rd_type;
    logic [`BRIDGE_ADDR_W-1:0]  data_rd_addr;
    logic                       data_rd_rdy;
    logic                       data_ret_valid;
    logic                       data_ret_last;
    logic [`BRIDGE_DATA_W-1:0]  data_ret_data;
    logic [`BRIDGE_ID_W-1:0]    arid;
    logic [`BRIDGE_ADDR_W-1:0]  araddr;
    logic [`BRIDGE_LEN_W-1:0]   arlen;
    logic [`BRIDGE_SIZE_W-1:0]  arsize;
    logic [`BRIDGE_BURST_W-1:0] arburst;
    logic                       arvalid;
    logic                       arready;
    logic [`BRIDGE_ID_W-1:0]    rid;
    logic [`BRIDGE_DATA_W-1:0]  rdata;
    logic                       rlast;
    logic                       rvalid;
    logic                       rready;
    logic [`BRIDGE_CNT_W-1:0]   inst_refills;
    logic [`BRIDGE_CNT_W-1:0]   data_refills;

    logic [CASE_W-1:0]         cases [NUM_CASES];
    logic [1:0]                waiting;
    logic                      burst;
    logic [`BRIDGE_ADDR_W-1:0] base;
    int                        owner;
    int                        last_win;
    int                        beat_k;
    int                        beats_total;
    int                        beats = 0;
    int                        errors = 0;
    int                        cycles = 0;

    clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) clock_gen_i (.aclk(aclk), .rst_n(rst_n));
    axi_mem_model mem_i (.*);
    core_read_bridge dut_i (.*);

    task automatic accept_request(input int side, input bridge_pkg::rd_type_t typ,
                                  input logic [`BRIDGE_ADDR_W-1:0] addr);
        int want;
        int n_beats;
        logic [`BRIDGE_LEN_W-1:0] exp_len;
        // on a tie the side that lost last time goes first
        want = (waiting == 2'b11) ? 1 - last_win : side;
        n_beats = (typ == bridge_pkg::RD_LINE) ? `BRIDGE_LINE_BEATS : 1;
        // axi length field counts beats minus one
        exp_len = `BRIDGE_LEN_W'(n_beats - 1);
        assert (want == side) else begin
            errors++;
            $display("port %0d was served while port %0d was due", side, want);
        end
        assert (!burst && arvalid && arready) else begin
            errors++;
            $display("request accepted without a clean address phase");
        end
        assert (araddr == addr) else begin
            errors++;
            $display("error: araddr got %h expected %h", araddr, addr);
        end
        assert (arlen == exp_len) else begin
            errors++;
            $display("error: arlen got %h expected %h", arlen, exp_len);
        end
        assert (arid == `BRIDGE_RD_ID) else begin
            errors++;
            $display("error: arid got %h expected %h", arid, `BRIDGE_RD_ID);
        end
        assert (arsize == `BRIDGE_AXI_SIZE_WORD) else begin
            errors++;
            $display("error: arsize got %h expected %h", arsize, `BRIDGE_AXI_SIZE_WORD);
        end
        assert (arburst == `BRIDGE_AXI_BURST_INCR) else begin
            errors++;
            $display("error: arburst got %h expected %h", arburst, `BRIDGE_AXI_BURST_INCR);
        end
        last_win = side;
        waiting[side] = 1'b0;
        owner = side;
        base = addr;
        beat_k = 0;
        beats_total = n_beats;
        burst = 1'b1;
    endtask

    task automatic check_beat(input int side, input logic valid, input logic last,
                              input logic [`BRIDGE_DATA_W-1:0] data);
        logic [`BRIDGE_DATA_W-1:0] exp_data;
        if (valid) begin
            exp_data = base + 32'(beat_k * 4);
            assert (burst && owner == side) else begin
                errors++;
                $display("return beat on port %0d which owns no burst", side);
            end
            assert (data == exp_data) else begin
                errors++;
                $display("error: %s_ret_data got %h expected %h",
                         side ? "data" : "inst", data, exp_data);
            end
            assert (last == (beat_k == beats_total - 1)) else begin
                errors++;
                $display("error: %s_ret_last got %h on beat %0d",
                         side ? "data" : "inst", last, beat_k);
            end
            beats++;
            beat_k++;
            if (beat_k == beats_total) begin
                burst = 1'b0;
            end
        end
    endtask

    initial begin
        logic [CASE_W-1:0] c;
        int exp_refills [2];
        exp_refills[0] = 0;
        exp_refills[1] = 0;
        waiting = 2'b00;
        burst = 1'b0;
        last_win = 1;
        inst_rd_req = 1'b0;
        inst_rd_type = bridge_pkg::RD_WORD;
        inst_rd_addr = '0;
        data_rd_req = 1'b0;
        data_rd_type = bridge_pkg::RD_WORD;
        data_rd_addr = '0;
        $readmemh("tests/refill_cases.txt", cases);
        @(posedge rst_n);
        @(negedge aclk);
        assert (!inst_rd_rdy && !data_rd_rdy && !inst_ret_valid && !data_ret_valid
                && !arvalid && !rready) else begin
            errors++;
            $display("handshake outputs not low after reset");
        end
        @(posedge aclk);
        for (int i = 0; i < NUM_CASES; i++) begin
            c = cases[i];
            waiting = {c[36], c[76]};
            if (c[76]) exp_refills[0]++;
            if (c[36]) exp_refills[1]++;
            inst_rd_req <= c[76];
            inst_rd_type <= bridge_pkg::rd_type_t'(c[74:72]);
            inst_rd_addr <= c[71:40];
            data_rd_req <= c[36];
            data_rd_type <= bridge_pkg::rd_type_t'(c[34:32]);
            data_rd_addr <= c[31:0];
            while (waiting != 2'b00 || burst) begin
                @(negedge aclk);
                if (inst_rd_req && inst_rd_rdy) accept_request(0, inst_rd_type, inst_rd_addr);
                if (data_rd_req && data_rd_rdy) accept_request(1, data_rd_type, data_rd_addr);
                check_beat(0, inst_ret_valid, inst_ret_last, inst_ret_data);
                check_beat(1, data_ret_valid, data_ret_last, data_ret_data);
                @(posedge aclk);
                // accepted side drops its request after the edge
                inst_rd_req <= waiting[0];
                data_rd_req <= waiting[1];
            end
        end
        @(negedge aclk);
        assert (inst_refills == `BRIDGE_CNT_W'(exp_refills[0])) else begin
            errors++;
            $display("error: inst_refills got %h expected %h", inst_refills, exp_refills[0]);
        end
        assert (data_refills == `BRIDGE_CNT_W'(exp_refills[1])) else begin
            errors++;
            $display("error: data_refills got %h expected %h", data_refills, exp_refills[1]);
        end
        $display("done: %0d cases, %0d beats, %0d errors", NUM_CASES, beats, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

module axi_mem_model (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic [`BRIDGE_ADDR_W-1:0] araddr,
    input  logic [`BRIDGE_LEN_W-1:0]  arlen,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`BRIDGE_ID_W-1:0]   rid,
    output logic [`BRIDGE_DATA_W-1:0] rdata,
    output logic                      rlast,
    output logic                      rvalid,
    input  logic                      rready
);

    logic [15:0]               lfsr;
    logic                      busy;
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic [`BRIDGE_LEN_W-1:0]  left;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    assign rid = `BRIDGE_RD_ID;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr    <= 16'd95;
            busy    <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            addr    <= '0;
            left    <= '0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy    <= 1'b1;
                arready <= 1'b0;
                addr    <= araddr;
                left    <= arlen;
            end else begin
                arready <= lfsr[0];
                lfsr    <= lfsr_next(lfsr);
            end
        end else if (rvalid && rready && rlast) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end else if (rvalid && rready) begin
            // next beat at once or after a stall
            addr   <= addr + 4;
            left   <= left - `BRIDGE_LEN_W'(1);
            rdata  <= addr + 4;
            rlast  <= (left == `BRIDGE_LEN_W'(1));
            rvalid <= lfsr[0];
            lfsr   <= lfsr_next(lfsr);
        end else if (!rvalid) begin
            // data is the word address of the beat
            rdata  <= addr;
            rlast  <= (left == '0);
            rvalid <= lfsr[0];
            lfsr   <= lfsr_next(lfsr);
        end
    end

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- design/core_read_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

module core_read_bridge (
    input  logic                       aclk,
    input  logic                       rst_n,
    // instruction cache side
    input  logic                       inst_rd_req,
    input  bridge_pkg::rd_type_t       inst_rd_type,
    input  logic [`BRIDGE_ADDR_W-1:0]  inst_rd_addr,
    output logic                       inst_rd_rdy,
    output logic                       inst_ret_valid,
    output logic                       inst_ret_last,
    output logic [`BRIDGE_DATA_W-1:0]  inst_ret_data,
    // data cache side
    input  logic                       data_rd_req,
    input  bridge_pkg::rd_type_t       data_rd_type,
    input  logic [`BRIDGE_ADDR_W-1:0]  data_rd_addr,
    output logic                       data_rd_rdy,
    output logic                       data_ret_valid,
    output logic                       data_ret_last,
    output logic [`BRIDGE_DATA_W-1:0]  data_ret_data,
    // axi read channel
    output logic [`BRIDGE_ID_W-1:0]    arid,
    output logic [`BRIDGE_ADDR_W-1:0]  araddr,
    output logic [`BRIDGE_LEN_W-1:0]   arlen,
    output logic [`BRIDGE_SIZE_W-1:0]  arsize,
    output logic [`BRIDGE_BURST_W-1:0] arburst,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`BRIDGE_ID_W-1:0]    rid,
    input  logic [`BRIDGE_DATA_W-1:0]  rdata,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready,
    // refill counts
    output logic [`BRIDGE_CNT_W-1:0]   inst_refills,
    output logic [`BRIDGE_CNT_W-1:0]   data_refills
);

    refill_if inst_port ();
    refill_if data_port ();
    refill_if bus_port ();

    assign inst_port.rd_req  = inst_rd_req;
    assign inst_port.rd_type = inst_rd_type;
    assign inst_port.rd_addr = inst_rd_addr;
    assign inst_rd_rdy       = inst_port.rd_rdy;
    assign inst_ret_valid    = inst_port.ret_valid;
    assign inst_ret_last     = inst_port.ret_last;
    assign inst_ret_data     = inst_port.ret_data;

    assign data_port.rd_req  = data_rd_req;
    assign data_port.rd_type = data_rd_type;
    assign data_port.rd_addr = data_rd_addr;
    assign data_rd_rdy       = data_port.rd_rdy;
    assign data_ret_valid    = data_port.ret_valid;
    assign data_ret_last     = data_port.ret_last;
    assign data_ret_data     = data_port.ret_data;

    refill_arbiter arbiter_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .inst_port (inst_port.bridge),
        .data_port (data_port.bridge),
        .bus_port  (bus_port.requester)
    );

    axi_read_master master_i (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .req     (bus_port.bridge),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    refill_counter counter_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .inst_port    (inst_port.monitor),
        .data_port    (data_port.monitor),
        .inst_refills (inst_refills),
        .data_refills (data_refills)
    );

endmodule

`default_nettype wire

//--- design/refill_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

module refill_counter (
    input  logic                     aclk,
    input  logic                     rst_n,
    refill_if.monitor                inst_port,
    refill_if.monitor                data_port,
    output logic [`BRIDGE_CNT_W-1:0] inst_refills,
    output logic [`BRIDGE_CNT_W-1:0] data_refills
);

    logic inst_accept;
    logic data_accept;

    assign inst_accept = inst_port.rd_req && inst_port.rd_rdy;
    assign data_accept = data_port.rd_req && data_port.rd_rdy;

    // counts wrap silently
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            inst_refills <= '0;
            data_refills <= '0;
        end else begin
            if (inst_accept) begin
                inst_refills <= inst_refills + 1'b1;
            end
            if (data_accept) begin
                data_refills <= data_refills + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/axi_read_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

module axi_read_master (
    input  logic                       aclk,
    input  logic                       rst_n,
    refill_if.bridge                   req,
    output logic [`BRIDGE_ID_W-1:0]    arid,
    output logic [`BRIDGE_ADDR_W-1:0]  araddr,
    output logic [`BRIDGE_LEN_W-1:0]   arlen,
    output logic [`BRIDGE_SIZE_W-1:0]  arsize,
    output logic [`BRIDGE_BURST_W-1:0] arburst,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`BRIDGE_ID_W-1:0]    rid,
    input  logic [`BRIDGE_DATA_W-1:0]  rdata,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready
);

    logic busy;
    logic r_beat;

    // address phase only while no burst is outstanding
    assign arvalid = !busy && req.rd_req;
    assign araddr  = req.rd_addr;
    assign arlen   = (req.rd_type == bridge_pkg::RD_LINE)
                     ? `BRIDGE_LEN_W'(`BRIDGE_LINE_BEATS - 1)
                     : '0;
    assign arid    = `BRIDGE_RD_ID;
    assign arsize  = `BRIDGE_AXI_SIZE_WORD;
    assign arburst = `BRIDGE_AXI_BURST_INCR;

    assign req.rd_rdy = !busy && arready;

    assign rready = busy;
    assign r_beat = rvalid && rready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (arvalid && arready) begin
            busy <= 1'b1;
        end else if (r_beat && rlast) begin
            busy <= 1'b0;
        end
    end

    // beats pass straight through to the owner
    assign req.ret_valid = r_beat;
    assign req.ret_last  = r_beat && rlast;
    assign req.ret_data  = rdata;

    a_ar_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen)
    ) else $error("arvalid dropped or araddr/arlen changed before arready");

    a_rid_match: assert property (
        @(posedge aclk) disable iff (!rst_n)
        r_beat |-> rid == `BRIDGE_RD_ID
    ) else $error("rid %h does not match read id", rid);

endmodule

`default_nettype wire

//--- design/refill_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

module refill_arbiter (
    input  logic       aclk,
    input  logic       rst_n,
    refill_if.bridge    inst_port,
    refill_if.bridge    data_port,
    refill_if.requester bus_port
);

    bridge_pkg::port_sel_t grant;
    bridge_pkg::port_sel_t owner;
    bridge_pkg::port_sel_t prio;
    logic                  accept;

    // last winner doubles as the round-robin pointer
    assign prio = (owner == bridge_pkg::PORT_INST) ? bridge_pkg::PORT_DATA
                                                   : bridge_pkg::PORT_INST;

    always_comb begin
        if (inst_port.rd_req && data_port.rd_req) begin
            grant = prio;
        end else if (data_port.rd_req) begin
            grant = bridge_pkg::PORT_DATA;
        end else begin
            grant = bridge_pkg::PORT_INST;
        end
    end

    assign bus_port.rd_req  = inst_port.rd_req || data_port.rd_req;
    assign bus_port.rd_type = (grant == bridge_pkg::PORT_DATA) ? data_port.rd_type
                                                               : inst_port.rd_type;
    assign bus_port.rd_addr = (grant == bridge_pkg::PORT_DATA) ? data_port.rd_addr
                                                               : inst_port.rd_addr;

    // ready back to the winner only
    assign inst_port.rd_rdy = bus_port.rd_rdy && inst_port.rd_req
                              && (grant == bridge_pkg::PORT_INST);
    assign data_port.rd_rdy = bus_port.rd_rdy && data_port.rd_req
                              && (grant == bridge_pkg::PORT_DATA);

    assign accept = bus_port.rd_req && bus_port.rd_rdy;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            // inst side wins the first tie
            owner <= bridge_pkg::PORT_DATA;
        end else if (accept) begin
            owner <= grant;
        end
    end

    // steer returns to whoever was accepted
    assign inst_port.ret_valid = bus_port.ret_valid && (owner == bridge_pkg::PORT_INST);
    assign inst_port.ret_last  = bus_port.ret_last && (owner == bridge_pkg::PORT_INST);
    assign inst_port.ret_data  = bus_port.ret_data;
    assign data_port.ret_valid = bus_port.ret_valid && (owner == bridge_pkg::PORT_DATA);
    assign data_port.ret_last  = bus_port.ret_last && (owner == bridge_pkg::PORT_DATA);
    assign data_port.ret_data  = bus_port.ret_data;

    // owner must not move while beats still flow to it
    a_no_accept_in_burst: assert property (
        @(posedge aclk) disable iff (!rst_n)
        accept |-> !bus_port.ret_valid
    ) else $error("request accepted while a return beat was in flight");

endmodule

`default_nettype wire

//--- design/refill_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_macros.svh"

interface refill_if;

    logic                rd_req;
    bridge_pkg::rd_type_t rd_type;
    bridge_pkg::addr_t   rd_addr;
    logic                rd_rdy;

    // return beats, no back-pressure
    logic                ret_valid;
    logic                ret_last;
    bridge_pkg::data_t   ret_data;

    modport requester (
        output rd_req, rd_type, rd_addr,
        input  rd_rdy, ret_valid, ret_last, ret_data
    );

    modport bridge (
        input  rd_req, rd_type, rd_addr,
        output rd_rdy, ret_valid, ret_last, ret_data
    );

    modport monitor (
        input rd_req, rd_type, rd_addr, rd_rdy, ret_valid, ret_last, ret_data
    );

endinterface

`default_nettype wire

//--- design/bridge_pkg.sv
`default_nettype none

`include "bridge_macros.svh"

package bridge_pkg;

    // refill kind, same encoding as the cache side rd_type
    typedef enum logic [2:0] {
        RD_WORD = 3'b010,
        RD_LINE = 3'b100
    } rd_type_t;

    // current owner of the shared read channel
    typedef enum logic {
        PORT_INST = 1'b0,
        PORT_DATA = 1'b1
    } port_sel_t;

    typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0] data_t;

endpackage

`default_nettype wire

//--- design/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

`define BRIDGE_ADDR_W          32
`define BRIDGE_DATA_W          32
`define BRIDGE_LINE_BEATS      4

// axi read channel field widths
`define BRIDGE_ID_W            4
`define BRIDGE_LEN_W           8
`define BRIDGE_SIZE_W          3
`define BRIDGE_BURST_W         2

`define BRIDGE_RD_ID           4'h0
`define BRIDGE_AXI_SIZE_WORD   3'b010
`define BRIDGE_AXI_BURST_INCR  2'b01

`define BRIDGE_CNT_W           16

`endif
